// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - verilog/rv_isa_pkg.sv
  - verilog/fetch_cfg_pkg.sv
  - verilog/icache.sv
  - verilog/branch_predictor.sv
  - verilog/fetch_sequencer.sv
  - verilog/fetch_unit.sv
  - target: test
    files:
      - dv/fetch_unit_assertions.sv
      - dv/fetch_unit_tb.sv

// ==== dv/fetch_unit_assertions.sv ====
module fetch_unit_assertions (
    input logic                                 clk_i,
    input logic                                 rst_i,
    input logic                                 mem_req_i,
    input logic                                 mem_valid_i,
    input logic [rv_isa_pkg::XLEN-1:0]          mem_addr_i,
    input logic                                 valid_i,
    input logic [rv_isa_pkg::XLEN-1:0]          instr_i
);

    import rv_isa_pkg::*;
    import fetch_cfg_pkg::*;

    localparam int unsigned LINE_ALIGN_BITS = $clog2(LINE_BITS / 8);

    int unsigned fail_count = 0;                        // read by the testbench at the end.

    req_held: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_i && !mem_valid_i |=> mem_req_i)
        else begin
            $error("mem_req_o dropped before mem_valid_i arrived.");
            fail_count++;
        end

    bubble_is_nop: assert property (@(posedge clk_i) disable iff (rst_i)
        !valid_i |-> instr_i == NOP_INSTR)
        else begin
            $error("instr_o is not a NOP while valid_o is low.");
            fail_count++;
        end

    req_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_i |-> mem_addr_i[LINE_ALIGN_BITS-1:0] == '0)
        else begin
            $error("mem_addr_o is not line aligned during a request.");
            fail_count++;
        end

endmodule

bind fetch_unit fetch_unit_assertions i_fetch_unit_assertions (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem_req_i   (mem_req_o),
    .mem_valid_i (mem_valid_i),
    .mem_addr_i  (mem_addr_o),
    .valid_i     (valid_o),
    .instr_i     (instr_o)
);

// ==== dv/fetch_unit_tb.sv ====
module fetch_unit_tb;

    import rv_isa_pkg::*;
    import fetch_cfg_pkg::*;

    localparam logic [XLEN-1:0] START_PC = 32'h0000_0100;
    localparam logic [XLEN-1:0] WORD_KEY = 32'hA5A5_0000;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int STALL_CYCLES = 5;

    localparam int OP_SEQ = 0;
    localparam int OP_MISP = 1;
    localparam int OP_JAL = 2;
    localparam int OP_BOTH = 3;
    localparam int OP_TRAIN = 4;
    localparam int OP_STALL = 5;

    typedef struct {
        string           name;
        int              op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] target;
        logic [XLEN-1:0] exp_pc;
        logic            exp_taken;
    } step_t;

    logic                 clk_i;
    logic                 rst_i;
    logic                 stall_i;
    logic                 mem_ready_i;
    logic                 mem_valid_i = 1'b0;
    logic [LINE_BITS-1:0] mem_line_i = '0;
    logic                 mem_req_o;
    logic [XLEN-1:0]      mem_addr_o;
    logic                 mispredict_i;
    logic [XLEN-1:0]      redirect_pc_i;
    logic                 jal_valid_i;
    logic [XLEN-1:0]      jal_pc_i;
    logic                 update_valid_i;
    logic [XLEN-1:0]      update_pc_i;
    logic                 update_taken_i;
    logic [XLEN-1:0]      update_target_i;
    logic                 valid_o;
    logic [XLEN-1:0]      pc_o;
    logic [XLEN-1:0]      instr_o;
    logic                 pred_taken_o;

    step_t           steps[$];
    logic [15:0]     lfsr_q = 16'd41494;
    logic            mem_busy = 1'b0;
    int              mem_wait;
    logic [XLEN-1:0] req_addr;

    fetch_unit #(.RESET_PC(START_PC)) i_fetch_unit (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] addr);
        return addr ^ WORD_KEY;
    endfunction

    function automatic logic [LINE_BITS-1:0] line_at(input logic [XLEN-1:0] base);
        logic [LINE_BITS-1:0] line;
        for (int w = 0; w < LINE_BITS / XLEN; w++) begin
            line[w*XLEN +: XLEN] = word_at(base + 32'(4 * w));
        end
        return line;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);   // x^16+x^14+x^13+x^11+1.
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic wait_valid(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Verification failed");
                $fatal(1, "timed out waiting for valid_o in step %s", name);
            end
        end while (!valid_o);
    endtask

    task automatic pulse_redirect(input logic misp, input logic [XLEN-1:0] misp_pc,
                                  input logic jal, input logic [XLEN-1:0] jal_target);
        @(posedge clk_i);
        mispredict_i <= misp;
        redirect_pc_i <= misp_pc;
        jal_valid_i <= jal;
        jal_pc_i <= jal_target;
        @(posedge clk_i);
        mispredict_i <= 1'b0;
        jal_valid_i <= 1'b0;
    endtask

    task automatic pulse_update(input logic [XLEN-1:0] pc, input logic taken,
                                input logic [XLEN-1:0] target);
        @(posedge clk_i);
        update_valid_i <= 1'b1;
        update_pc_i <= pc;
        update_taken_i <= taken;
        update_target_i <= target;
        @(posedge clk_i);
        update_valid_i <= 1'b0;
    endtask

    task automatic add_step(input string name, input int op, input logic [XLEN-1:0] addr,
                            input logic [XLEN-1:0] target, input logic [XLEN-1:0] exp_pc,
                            input logic exp_taken);
        steps.push_back('{name, op, addr, target, exp_pc, exp_taken});
    endtask

    // memory answers one line request at a time after 1 to 4 cycles.
    always @(posedge clk_i) begin
        mem_valid_i <= 1'b0;
        if (rst_i) begin
            mem_busy = 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_valid_i <= 1'b1;
                mem_line_i <= line_at(req_addr);
                mem_busy = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end else if (mem_req_o && !mem_valid_i) begin
            req_addr = mem_addr_o;
            check_value("refill alignment", '0, {28'h0, req_addr[3:0]});
            mem_wait = 0;
            for (int b = 0; b < 2; b++) begin
                mem_wait = mem_wait | (int'(lfsr_q[0]) << b);
                lfsr_q = lfsr_next(lfsr_q);
            end
            mem_busy = 1'b1;
        end
    end

    initial begin
        logic            hold_valid;
        logic [XLEN-1:0] hold_pc;
        logic [XLEN-1:0] hold_instr;
        rst_i <= 1'b1;
        stall_i <= 1'b0;
        mem_ready_i <= 1'b1;
        mispredict_i <= 1'b0;
        redirect_pc_i <= '0;
        jal_valid_i <= 1'b0;
        jal_pc_i <= '0;
        update_valid_i <= 1'b0;
        update_pc_i <= '0;
        update_taken_i <= 1'b0;
        update_target_i <= '0;

        add_step("reset pc", OP_SEQ, '0, '0, 32'h100, 1'b0);
        add_step("seq 104", OP_SEQ, '0, '0, 32'h104, 1'b0);
        add_step("seq 108", OP_SEQ, '0, '0, 32'h108, 1'b0);
        add_step("seq 10c", OP_SEQ, '0, '0, 32'h10C, 1'b0);
        add_step("line miss", OP_SEQ, '0, '0, 32'h110, 1'b0);
        add_step("hit after miss", OP_SEQ, '0, '0, 32'h114, 1'b0);
        add_step("mispredict", OP_MISP, 32'h200, '0, 32'h200, 1'b0);
        add_step("after mispredict", OP_SEQ, '0, '0, 32'h204, 1'b0);
        add_step("jal", OP_JAL, 32'h300, '0, 32'h300, 1'b0);
        add_step("mispredict and jal", OP_BOTH, 32'h400, 32'h500, 32'h400, 1'b0);
        add_step("train taken", OP_TRAIN, 32'h440, 32'h600, 32'h440, 1'b1);
        add_step("predicted target", OP_SEQ, '0, '0, 32'h600, 1'b0);
        add_step("after target", OP_SEQ, '0, '0, 32'h604, 1'b0);
        add_step("train not taken", OP_TRAIN, 32'h440, 32'h600, 32'h440, 1'b0);
        add_step("fall through", OP_SEQ, '0, '0, 32'h444, 1'b0);
        add_step("stall", OP_STALL, '0, '0, 32'h44C, 1'b0);
        add_step("after stall", OP_SEQ, '0, '0, 32'h450, 1'b0);

        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("reset valid_o", '0, valid_o);
        check_value("reset mem_req_o", '0, mem_req_o);
        check_value("reset instr_o", NOP_INSTR, instr_o);

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_MISP: pulse_redirect(1'b1, steps[i].addr, 1'b0, '0);
                OP_JAL: pulse_redirect(1'b0, '0, 1'b1, steps[i].addr);
                OP_BOTH: pulse_redirect(1'b1, steps[i].addr, 1'b1, steps[i].target);
                OP_TRAIN: begin
                    pulse_update(steps[i].addr, steps[i].exp_taken, steps[i].target);
                    pulse_update(steps[i].addr, steps[i].exp_taken, steps[i].target);
                    pulse_redirect(1'b0, '0, 1'b1, steps[i].addr);   // refetch the branch.
                end
                OP_STALL: begin
                    @(posedge clk_i);
                    stall_i <= 1'b1;
                    @(negedge clk_i);
                    hold_valid = valid_o;
                    hold_pc = pc_o;
                    hold_instr = instr_o;
                    repeat (STALL_CYCLES) begin
                        @(negedge clk_i);
                        check_value({steps[i].name, " valid_o"}, hold_valid, valid_o);
                        check_value({steps[i].name, " pc_o"}, hold_pc, pc_o);
                        check_value({steps[i].name, " instr_o"}, hold_instr, instr_o);
                    end
                    @(posedge clk_i);
                    stall_i <= 1'b0;
                    @(posedge clk_i);                      // first edge that fetches again.
                end
                default: ;
            endcase
            wait_valid(steps[i].name);
            check_value({steps[i].name, " pc_o"}, steps[i].exp_pc, pc_o);
            check_value({steps[i].name, " instr_o"}, word_at(steps[i].exp_pc), instr_o);
            check_value({steps[i].name, " pred_taken_o"}, steps[i].exp_taken, pred_taken_o);
        end

        if (i_fetch_unit.i_fetch_unit_assertions.fail_count != 0) begin
            $display("Verification failed");
            $fatal(1, "protocol assertions fired during the run");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
verilog/rv_isa_pkg.sv
verilog/fetch_cfg_pkg.sv
verilog/icache.sv
verilog/branch_predictor.sv
verilog/fetch_sequencer.sv
verilog/fetch_unit.sv
dv/fetch_unit_assertions.sv
dv/fetch_unit_tb.sv

// ==== verilog/branch_predictor.sv ====
module branch_predictor (
    input  logic                         clk_i,
    input  logic                         rst_i,

    input  fetch_cfg_pkg::fetch_addr_t   fetch_pc_i,
    output logic                         pred_taken_o,
    output logic [rv_isa_pkg::XLEN-1:0]  pred_target_o,

    input  logic                         update_valid_i,
    input  fetch_cfg_pkg::fetch_addr_t   update_pc_i,
    input  logic                         update_taken_i,
    input  logic [rv_isa_pkg::XLEN-1:0]  update_target_i
);

    import rv_isa_pkg::*;
    import fetch_cfg_pkg::*;

    logic [BTB_ENTRIES-1:0]  valid_q;
    logic [BTB_TAG_BITS-1:0] tag_q [BTB_ENTRIES];
    logic [XLEN-1:0]         target_q [BTB_ENTRIES];
    logic [1:0]              cnt_q [BTB_ENTRIES];

    logic [BTB_IDX_BITS-1:0] rd_idx;
    logic                    rd_match;

    logic [BTB_IDX_BITS-1:0] upd_idx;
    logic                    upd_match;
    logic [1:0]              upd_cnt;
    logic [1:0]              upd_cnt_next;

    assign rd_idx = fetch_pc_i.btb.index;
    assign rd_match = valid_q[rd_idx] && (tag_q[rd_idx] == fetch_pc_i.btb.tag);

    assign pred_taken_o = rd_match && cnt_q[rd_idx][1];   // weakly or strongly taken.
    assign pred_target_o = target_q[rd_idx];

    assign upd_idx = update_pc_i.btb.index;
    assign upd_match = valid_q[upd_idx] && (tag_q[upd_idx] == update_pc_i.btb.tag);
    assign upd_cnt = cnt_q[upd_idx];

    always_comb begin
        upd_cnt_next = upd_cnt;
        if (update_taken_i && upd_cnt != 2'b11) begin
            upd_cnt_next = upd_cnt + 2'b01;
        end else if (!update_taken_i && upd_cnt != 2'b00) begin
            upd_cnt_next = upd_cnt - 2'b01;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (update_valid_i && !upd_match && update_taken_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_valid_i) begin
            if (upd_match) begin
                cnt_q[upd_idx] <= upd_cnt_next;
                target_q[upd_idx] <= update_target_i;
            end else if (update_taken_i) begin
                tag_q[upd_idx] <= update_pc_i.btb.tag;   // a not-taken miss allocates nothing.
                target_q[upd_idx] <= update_target_i;
                cnt_q[upd_idx] <= 2'b10;
            end
        end
    end

endmodule

// ==== verilog/fetch_cfg_pkg.sv ====
package fetch_cfg_pkg;

    localparam int unsigned LINE_BITS = 128;
    localparam int unsigned CACHE_SETS = 16;
    localparam int unsigned BTB_ENTRIES = 16;

    localparam int unsigned ADDR_BITS = 32;
    localparam int unsigned BYTE_BITS = 2;                      // byte within a word.
    localparam int unsigned LINE_WORDS = LINE_BITS / ADDR_BITS;
    localparam int unsigned OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int unsigned SET_BITS = $clog2(CACHE_SETS);
    localparam int unsigned BTB_IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int unsigned CACHE_TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS - BYTE_BITS;
    localparam int unsigned BTB_TAG_BITS = ADDR_BITS - BTB_IDX_BITS - BYTE_BITS;

    // Cache set comes from bits 7:4 and the BTB index from bits 5:2.
    typedef union packed {
        struct packed {
            logic [CACHE_TAG_BITS-1:0] tag;
            logic [SET_BITS-1:0]       set;
            logic [OFFSET_BITS-1:0]    offset;
            logic [BYTE_BITS-1:0]      byte_sel;
        } cache;
        struct packed {
            logic [BTB_TAG_BITS-1:0] tag;
            logic [BTB_IDX_BITS-1:0] index;
            logic [BYTE_BITS-1:0]    align;
        } btb;
    } fetch_addr_t;

endpackage

// ==== verilog/fetch_sequencer.sv ====
module fetch_sequencer #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         stall_i,

    input  logic                         hit_i,
    input  logic [rv_isa_pkg::XLEN-1:0]  hit_instr_i,
    input  logic                         pred_taken_i,
    input  logic [rv_isa_pkg::XLEN-1:0]  pred_target_i,

    input  logic                         mispredict_i,
    input  logic [rv_isa_pkg::XLEN-1:0]  redirect_pc_i,
    input  logic                         jal_valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0]  jal_pc_i,

    output logic [rv_isa_pkg::XLEN-1:0]  fetch_pc_o,
    output logic                         fetch_stall_o,

    output logic                         valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]  pc_o,
    output logic [rv_isa_pkg::XLEN-1:0]  instr_o,
    output logic                         pred_taken_o
);

    import rv_isa_pkg::*;

    logic            redirect;
    logic [XLEN-1:0] redirect_target;
    logic [XLEN-1:0] pc_q;

    assign redirect = mispredict_i | jal_valid_i;
    assign redirect_target = mispredict_i ? redirect_pc_i : jal_pc_i;   // mispredict wins.

    assign fetch_pc_o = pc_q;
    assign fetch_stall_o = stall_i | redirect;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_target;
        end else if (!stall_i && hit_i) begin
            pc_q <= pred_taken_i ? pred_target_i : pc_q + INSTR_BYTES;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            instr_o <= NOP_INSTR;
            pred_taken_o <= 1'b0;
        end else if (redirect || (!stall_i && !hit_i)) begin
            valid_o <= 1'b0;                               // bubble.
            instr_o <= NOP_INSTR;
            pred_taken_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= 1'b1;
            instr_o <= hit_instr_i;
            pred_taken_o <= pred_taken_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!redirect && !stall_i && hit_i) begin
            pc_o <= pc_q;
        end
    end

endmodule

// ==== verilog/fetch_unit.sv ====
module fetch_unit #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  stall_i,

    input  logic                                  mem_ready_i,
    input  logic                                  mem_valid_i,
    input  logic [fetch_cfg_pkg::LINE_BITS-1:0]   mem_line_i,
    output logic                                  mem_req_o,
    output logic [rv_isa_pkg::XLEN-1:0]           mem_addr_o,

    input  logic                                  mispredict_i,
    input  logic [rv_isa_pkg::XLEN-1:0]           redirect_pc_i,
    input  logic                                  jal_valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0]           jal_pc_i,

    input  logic                                  update_valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0]           update_pc_i,
    input  logic                                  update_taken_i,
    input  logic [rv_isa_pkg::XLEN-1:0]           update_target_i,

    output logic                                  valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]           pc_o,
    output logic [rv_isa_pkg::XLEN-1:0]           instr_o,
    output logic                                  pred_taken_o
);

    import rv_isa_pkg::*;
    import fetch_cfg_pkg::*;

    fetch_addr_t     fetch_pc;
    logic            fetch_stall;
    logic            hit;
    logic [XLEN-1:0] hit_instr;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;

    icache i_icache (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_pc_i    (fetch_pc),
        .fetch_stall_i (fetch_stall),
        .hit_o         (hit),
        .hit_instr_o   (hit_instr),
        .mem_ready_i   (mem_ready_i),
        .mem_valid_i   (mem_valid_i),
        .mem_line_i    (mem_line_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o)
    );

    branch_predictor i_branch_predictor (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .fetch_pc_i      (fetch_pc),
        .pred_taken_o    (pred_taken),
        .pred_target_o   (pred_target),
        .update_valid_i  (update_valid_i),
        .update_pc_i     (update_pc_i),
        .update_taken_i  (update_taken_i),
        .update_target_i (update_target_i)
    );

    fetch_sequencer #(
        .RESET_PC (RESET_PC)
    ) i_fetch_sequencer (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .hit_i         (hit),
        .hit_instr_i   (hit_instr),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .mispredict_i  (mispredict_i),
        .redirect_pc_i (redirect_pc_i),
        .jal_valid_i   (jal_valid_i),
        .jal_pc_i      (jal_pc_i),
        .fetch_pc_o    (fetch_pc),
        .fetch_stall_o (fetch_stall),
        .valid_o       (valid_o),
        .pc_o          (pc_o),
        .instr_o       (instr_o),
        .pred_taken_o  (pred_taken_o)
    );

endmodule

// ==== verilog/icache.sv ====
module icache (
    input  logic                                  clk_i,
    input  logic                                  rst_i,

    input  fetch_cfg_pkg::fetch_addr_t            fetch_pc_i,
    input  logic                                  fetch_stall_i,
    output logic                                  hit_o,
    output logic [rv_isa_pkg::XLEN-1:0]           hit_instr_o,

    input  logic                                  mem_ready_i,
    input  logic                                  mem_valid_i,
    input  logic [fetch_cfg_pkg::LINE_BITS-1:0]   mem_line_i,
    output logic                                  mem_req_o,
    output logic [rv_isa_pkg::XLEN-1:0]           mem_addr_o
);

    import rv_isa_pkg::*;
    import fetch_cfg_pkg::*;

    localparam logic S_IDLE = 1'b0;
    localparam logic S_REQ = 1'b1;

    logic [CACHE_TAG_BITS-1:0] tag_q [CACHE_SETS];
    logic [LINE_BITS-1:0]      line_q [CACHE_SETS];
    logic [CACHE_SETS-1:0]     valid_q;

    logic                      state_q;
    fetch_addr_t               refill_addr_q;

    logic [SET_BITS-1:0]       lookup_set;
    logic [LINE_BITS-1:0]      lookup_line;
    logic                      start_refill;

    assign lookup_set = fetch_pc_i.cache.set;
    assign lookup_line = line_q[lookup_set];

    assign hit_o = valid_q[lookup_set] && (tag_q[lookup_set] == fetch_pc_i.cache.tag);
    assign hit_instr_o = lookup_line[fetch_pc_i.cache.offset * XLEN +: XLEN];

    // a refill is only started for a fetch that the sequencer really waits on.
    assign start_refill = (state_q == S_IDLE) && !hit_o && !fetch_stall_i && mem_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_refill) begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (mem_valid_i) begin
                        state_q <= S_IDLE;                 // line lands this cycle.
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_refill) begin
            refill_addr_q <= fetch_pc_i;
            refill_addr_q.cache.offset <= '0;
            refill_addr_q.cache.byte_sel <= '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (state_q == S_REQ && mem_valid_i) begin
            valid_q[refill_addr_q.cache.set] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_REQ && mem_valid_i) begin
            tag_q[refill_addr_q.cache.set] <= refill_addr_q.cache.tag;
            line_q[refill_addr_q.cache.set] <= mem_line_i;
        end
    end

    assign mem_req_o = (state_q == S_REQ);
    assign mem_addr_o = refill_addr_q;

endmodule

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int unsigned XLEN = 32;
    localparam int unsigned INSTR_BYTES = 4;

    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [2:0] FUNCT3_ADDI = 3'b000;
    localparam logic [4:0] REG_X0 = 5'd0;

    // addi x0, x0, 0 is the canonical bubble.
    localparam logic [XLEN-1:0] NOP_INSTR = {
        12'd0,
        REG_X0,
        FUNCT3_ADDI,
        REG_X0,
        OPCODE_OP_IMM
    };

endpackage
